// File: all.f
mmacc_geom_pkg.sv
mmacc_cmd_pkg.sv
mmacc_fifo.sv
mmacc_gram.sv
mmacc_feed.sv
mmacc_acc.sv
mmacc_sxt.sv
mmacc_main.sv
mmacc_checker.sv
tb_mmacc_main.sv

// File: Bender.yml
package:
  name: mmacc

sources:
  - files:
      - mmacc_geom_pkg.sv
      - mmacc_cmd_pkg.sv
      - mmacc_fifo.sv
      - mmacc_gram.sv
      - mmacc_feed.sv
      - mmacc_acc.sv
      - mmacc_sxt.sv
      - mmacc_main.sv
  - target: test
    files:
      - mmacc_checker.sv
      - tb_mmacc_main.sv

// File: tb_mmacc_main.sv
// Testbench for mmacc_main. Four commands on distinct slots run back to back;
// the result stream stands in for the external product, one row per command.
`timescale 1ns/1ps
`default_nettype none

module tb_mmacc_main;

  localparam int NROWS       = 4;
  localparam int N           = mmacc_geom_pkg::N_COEF;
  localparam int TIMEOUT_CYC = 400;
  localparam int EV_ENQ      = 0;
  localparam int EV_EOP      = 1;
  localparam int EV_DONE     = 2;

  logic                        clk;
  logic                        s_rst_n;
  mmacc_cmd_pkg::gram_wr_t     ld_i;
  logic                        cmd_avail_i;
  mmacc_cmd_pkg::pbs_cmd_t     cmd_i;
  logic                        res_avail_i;
  mmacc_geom_pkg::coef_t       res_i;
  logic                        cmd_enquiry_o;
  mmacc_cmd_pkg::feed_out_t    feed_o;
  mmacc_cmd_pkg::sxt_out_t     sxt_o;
  logic                        done_o;
  mmacc_geom_pkg::slot_t       done_slot_o;
  mmacc_cmd_pkg::mmacc_error_t error_o;

  // Stimulus table and the expected streams derived from it
  mmacc_geom_pkg::slot_t     [NROWS-1:0]        slot_tbl;
  mmacc_geom_pkg::coef_idx_t [NROWS-1:0]        rot_tbl;
  mmacc_geom_pkg::coef_t     [NROWS-1:0][N-1:0] init_tbl;
  mmacc_geom_pkg::coef_t     [NROWS-1:0][N-1:0] res_tbl;
  mmacc_geom_pkg::coef_t     [NROWS-1:0][N-1:0] exp_feed;
  mmacc_geom_pkg::coef_t     [NROWS-1:0][N-1:0] exp_sxt;

  int   enq_cnt;
  int   eop_cnt;
  int   done_cnt;
  int   errors;
  int   seed;
  logic timed_out;

  mmacc_main #(
    .CMD_FIFO_DEPTH(2), .ACC_FIFO_DEPTH(4), .RES_FIFO_DEPTH(16), .ENQ_DELAY(8)
  ) DUT (
    .clk(clk), .s_rst_n(s_rst_n), .ld_i(ld_i),
    .cmd_avail_i(cmd_avail_i), .cmd_i(cmd_i),
    .res_avail_i(res_avail_i), .res_i(res_i),
    .cmd_enquiry_o(cmd_enquiry_o), .feed_o(feed_o), .sxt_o(sxt_o),
    .done_o(done_o), .done_slot_o(done_slot_o), .error_o(error_o)
  );

  mmacc_checker #(.NROWS(NROWS)) u_checker (
    .clk(clk), .s_rst_n(s_rst_n), .cmd_enquiry_i(cmd_enquiry_o),
    .feed_i(feed_o), .sxt_i(sxt_o), .done_i(done_o), .done_slot_i(done_slot_o),
    .error_i(error_o), .slot_tbl_i(slot_tbl), .exp_feed_i(exp_feed),
    .exp_sxt_i(exp_sxt), .enq_cnt_o(enq_cnt), .eop_cnt_o(eop_cnt),
    .done_cnt_o(done_cnt)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // ------------------------------------------------------------
  // Table
  // ------------------------------------------------------------
  task automatic build_table();
    mmacc_geom_pkg::coef_t acc [N];
    int src;
    slot_tbl[0] = 2'd2;
    slot_tbl[1] = 2'd0;
    slot_tbl[2] = 2'd3;
    slot_tbl[3] = 2'd1;
    rot_tbl[0]  = '0;
    rot_tbl[1]  = mmacc_geom_pkg::coef_idx_t'(1);
    rot_tbl[2]  = mmacc_geom_pkg::coef_idx_t'(N - 1);
    rot_tbl[3]  = mmacc_geom_pkg::coef_idx_t'(3);
    for (int r = 0; r < NROWS; r++) begin
      for (int k = 0; k < N; k++) begin
        init_tbl[r][k] = mmacc_geom_pkg::coef_t'($random(seed));
        // Row 1 sits just below the modulus, so its sums wrap
        res_tbl[r][k]  = (r == 1) ? mmacc_geom_pkg::coef_t'(16'hFFF0 + k)
                                  : mmacc_geom_pkg::coef_t'($random(seed));
      end
      // Negacyclic rotation, then accumulate in index order
      for (int j = 0; j < N; j++) begin
        src = (j - int'(rot_tbl[r]) + N) % N;
        exp_feed[r][j] = (j < int'(rot_tbl[r])) ? -init_tbl[r][src] : init_tbl[r][src];
        acc[j] = init_tbl[r][j] + res_tbl[r][j];
      end
      // Sample extraction order
      for (int j = 0; j < N; j++) begin
        exp_sxt[r][j] = (j == 0) ? acc[0] : -acc[N - j];
      end
    end
  endtask

  function automatic int event_count(input int kind);
    case (kind)
      EV_ENQ:  return enq_cnt;
      EV_EOP:  return eop_cnt;
      default: return done_cnt;
    endcase
  endfunction

  task automatic wait_events(input int kind, input int target, input string what);
    int cycles;
    cycles = 0;
    while (!timed_out && event_count(kind) < target) begin
      @(posedge clk);
      cycles++;
      if (cycles > TIMEOUT_CYC) begin
        $display("Timeout at %0t: waited %0d cycles for %s number %0d",
                 $time, TIMEOUT_CYC, what, target);
        timed_out = 1'b1;
      end
    end
  endtask

  // ------------------------------------------------------------
  // Drivers
  // ------------------------------------------------------------
  task automatic load_slots();
    for (int r = 0; r < NROWS; r++) begin
      for (int k = 0; k < N; k++) begin
        @(posedge clk);
        #1;
        ld_i.en       = 1'b1;
        ld_i.add.slot = slot_tbl[r];
        ld_i.add.idx  = mmacc_geom_pkg::coef_idx_t'(k);
        ld_i.data     = init_tbl[r][k];
      end
    end
    @(posedge clk);
    #1;
    ld_i = '0;
  endtask

  // One command per enquiry pulse
  task automatic send_commands();
    for (int r = 0; r < NROWS; r++) begin
      wait_events(EV_ENQ, r + 1, "command enquiry");
      @(posedge clk);
      #1;
      cmd_avail_i = 1'b1;
      cmd_i.slot  = slot_tbl[r];
      cmd_i.rot   = rot_tbl[r];
      @(posedge clk);
      #1;
      cmd_avail_i = 1'b0;
    end
  endtask

  // Results of a command follow its feed end flag
  task automatic return_results();
    for (int r = 0; r < NROWS; r++) begin
      wait_events(EV_EOP, r + 1, "feed end flag");
      for (int k = 0; k < N; k++) begin
        @(posedge clk);
        #1;
        res_avail_i = 1'b1;
        res_i       = res_tbl[r][k];
      end
      @(posedge clk);
      #1;
      res_avail_i = 1'b0;
    end
  endtask

  initial begin
    s_rst_n     = 1'b0;
    ld_i        = '0;
    cmd_avail_i = 1'b0;
    cmd_i       = '0;
    res_avail_i = 1'b0;
    res_i       = '0;
    timed_out   = 1'b0;
    seed        = 92;
    build_table();
    repeat (10) @(posedge clk);
    #1;
    s_rst_n = 1'b1;
    load_slots();
    fork
      send_commands();
      return_results();
    join
    wait_events(EV_DONE, NROWS, "done pulse");
    // Drain, so stray outputs are still seen
    repeat (2 * N) @(posedge clk);
    errors = u_checker.report();
    if (timed_out || errors != 0) begin
      $display("FAIL: see errors above");
    end else begin
      $display("PASS: all tests");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: mmacc_checker.sv
// Testbench monitor. Follows feed_o and sxt_o in command order, samples on the
// falling edge and compares against the expected tables of the testbench.
`timescale 1ns/1ps
`default_nettype none

module mmacc_checker #(
  parameter int NROWS = 4,
  parameter int N     = mmacc_geom_pkg::N_COEF
) (
  input  wire logic                                    clk,
  input  wire logic                                    s_rst_n,
  input  wire logic                                    cmd_enquiry_i,
  input  wire mmacc_cmd_pkg::feed_out_t                feed_i,
  input  wire mmacc_cmd_pkg::sxt_out_t                 sxt_i,
  input  wire logic                                    done_i,
  input  wire mmacc_geom_pkg::slot_t                   done_slot_i,
  input  wire mmacc_cmd_pkg::mmacc_error_t             error_i,
  input  wire mmacc_geom_pkg::slot_t [NROWS-1:0]       slot_tbl_i,
  input  wire mmacc_geom_pkg::coef_t [NROWS-1:0][N-1:0] exp_feed_i,
  input  wire mmacc_geom_pkg::coef_t [NROWS-1:0][N-1:0] exp_sxt_i,
  output int                                           enq_cnt_o,
  output int                                           eop_cnt_o,
  output int                                           done_cnt_o
);

  int   err_cnt;
  int   feed_row;
  int   feed_idx;
  int   sxt_row;
  int   sxt_idx;
  int   row_err [NROWS];
  logic err_seen;

  task automatic mismatch(input string sig, input logic [31:0] exp_v,
                          input logic [31:0] act_v, input int row);
    $display("MISMATCH at %0t: %s expected %0h, got %0h (row %0d)",
             $time, sig, exp_v, act_v, row);
    err_cnt++;
    if (row >= 0 && row < NROWS) begin
      row_err[row]++;
    end
  endtask

  task automatic check_feed();
    if (feed_row >= NROWS) begin
      $display("Feed coefficient at %0t after the last command", $time);
      err_cnt++;
    end else begin
      if (feed_i.data !== exp_feed_i[feed_row][feed_idx]) begin
        mismatch("feed_o.data", exp_feed_i[feed_row][feed_idx], feed_i.data, feed_row);
      end
      if (feed_i.sop !== (feed_idx == 0)) begin
        mismatch("feed_o.sop", feed_idx == 0, feed_i.sop, feed_row);
      end
      if (feed_i.eop !== (feed_idx == N - 1)) begin
        mismatch("feed_o.eop", feed_idx == N - 1, feed_i.eop, feed_row);
      end
      feed_row = (feed_idx == N - 1) ? feed_row + 1 : feed_row;
      feed_idx = (feed_idx == N - 1) ? 0 : feed_idx + 1;
    end
  endtask

  task automatic check_sxt();
    logic last_exp;
    if (sxt_row >= NROWS) begin
      $display("Extract coefficient at %0t after the last command", $time);
      err_cnt++;
    end else begin
      last_exp = (sxt_idx == N - 1);
      if (sxt_i.data !== exp_sxt_i[sxt_row][sxt_idx]) begin
        mismatch("sxt_o.data", exp_sxt_i[sxt_row][sxt_idx], sxt_i.data, sxt_row);
      end
      if (sxt_i.slot !== slot_tbl_i[sxt_row]) begin
        mismatch("sxt_o.slot", slot_tbl_i[sxt_row], sxt_i.slot, sxt_row);
      end
      if (sxt_i.last !== last_exp) begin
        mismatch("sxt_o.last", last_exp, sxt_i.last, sxt_row);
      end
      if (done_i !== last_exp) begin
        mismatch("done_o", last_exp, done_i, sxt_row);
      end else if (done_i && done_slot_i !== slot_tbl_i[sxt_row]) begin
        mismatch("done_slot_o", slot_tbl_i[sxt_row], done_slot_i, sxt_row);
      end
      if (last_exp) begin
        $display("Test %0d on slot %0d: %s", sxt_row, slot_tbl_i[sxt_row],
                 (row_err[sxt_row] == 0) ? "passed" : "failed");
        sxt_row++;
      end
      sxt_idx = last_exp ? 0 : sxt_idx + 1;
    end
  endtask

  always @(negedge clk) begin
    if (!s_rst_n) begin
      enq_cnt_o  = 0;
      eop_cnt_o  = 0;
      done_cnt_o = 0;
      err_cnt    = 0;
      feed_row   = 0;
      feed_idx   = 0;
      sxt_row    = 0;
      sxt_idx    = 0;
      err_seen   = 1'b0;
      foreach (row_err[r]) begin
        row_err[r] = 0;
      end
    end else begin
      if (cmd_enquiry_i) begin
        enq_cnt_o++;
      end
      if (feed_i.vld) begin
        check_feed();
        eop_cnt_o = feed_i.eop ? eop_cnt_o + 1 : eop_cnt_o;
      end
      if (done_i) begin
        done_cnt_o++;
      end
      if (sxt_i.vld) begin
        check_sxt();
      end else if (done_i) begin
        mismatch("done_o", 0, 1, sxt_row);
      end
      // Sticky flags, reported once
      if (error_i != '0 && !err_seen) begin
        mismatch("error_o", 0, error_i, -1);
        err_seen = 1'b1;
      end
    end
  end

  // Closing counts, returns the number of errors
  function automatic int report();
    int failed;
    failed = 0;
    if (enq_cnt_o != NROWS + 1) begin
      $display("Saw %0d command enquiry pulses where %0d were due", enq_cnt_o, NROWS + 1);
      err_cnt++;
    end
    if (done_cnt_o != NROWS) begin
      $display("Saw %0d done pulses where %0d were due", done_cnt_o, NROWS);
      err_cnt++;
    end
    for (int r = 0; r < NROWS; r++) begin
      if (row_err[r] != 0 || r >= sxt_row) begin
        failed++;
      end
    end
    $display("Summary: %0d tests, %0d failed, %0d errors", NROWS, failed, err_cnt);
    return err_cnt + failed;
  endfunction

endmodule

`default_nettype wire

// File: mmacc_main.sv
// Reduced main accumulator. Feed, accumulate and sample extract run in
// parallel on distinct slots, linked by command FIFOs, sharing one RAM port.
// No back-pressure; FIFO overflows only set the sticky error flags.
`timescale 1ns/1ps
`default_nettype none

module mmacc_main #(
  parameter int CMD_FIFO_DEPTH = 2,
  parameter int ACC_FIFO_DEPTH = 4,
  parameter int RES_FIFO_DEPTH = 16,
  parameter int ENQ_DELAY      = 8
) (
  input  wire logic                    clk,
  input  wire logic                    s_rst_n,
  input  wire mmacc_cmd_pkg::gram_wr_t ld_i,
  input  wire logic                    cmd_avail_i,
  input  wire mmacc_cmd_pkg::pbs_cmd_t cmd_i,
  input  wire logic                    res_avail_i,
  input  wire mmacc_geom_pkg::coef_t   res_i,
  output logic                         cmd_enquiry_o,
  output mmacc_cmd_pkg::feed_out_t     feed_o,
  output mmacc_cmd_pkg::sxt_out_t      sxt_o,
  output logic                         done_o,
  output mmacc_geom_pkg::slot_t        done_slot_o,
  output mmacc_cmd_pkg::mmacc_error_t  error_o
);

  // ------------------------------------------------------------
  // FIFOs
  // ------------------------------------------------------------
  mmacc_cmd_pkg::pbs_cmd_t    cfifo_data;
  logic                       cfifo_ne, cfifo_pop, cfifo_ovf;
  mmacc_cmd_pkg::intern_cmd_t afifo_in, afifo_out;
  logic                       afifo_push, afifo_ne, afifo_pop, afifo_ovf;
  mmacc_cmd_pkg::intern_cmd_t sfifo_in, sfifo_out;
  logic                       sfifo_push, sfifo_ne, sfifo_pop, sfifo_ovf;
  mmacc_geom_pkg::coef_t      rfifo_data;
  logic                       rfifo_ne, rfifo_pop, rfifo_ovf;

  mmacc_fifo #(.DEPTH(CMD_FIFO_DEPTH), .payload_t(mmacc_cmd_pkg::pbs_cmd_t)) u_cmd_fifo (
    .clk(clk), .s_rst_n(s_rst_n), .push_i(cmd_avail_i), .data_i(cmd_i),
    .pop_i(cfifo_pop), .data_o(cfifo_data), .not_empty_o(cfifo_ne), .ovf_o(cfifo_ovf)
  );

  mmacc_fifo #(.DEPTH(ACC_FIFO_DEPTH), .payload_t(mmacc_cmd_pkg::intern_cmd_t)) u_acc_fifo (
    .clk(clk), .s_rst_n(s_rst_n), .push_i(afifo_push), .data_i(afifo_in),
    .pop_i(afifo_pop), .data_o(afifo_out), .not_empty_o(afifo_ne), .ovf_o(afifo_ovf)
  );

  mmacc_fifo #(.DEPTH(ACC_FIFO_DEPTH), .payload_t(mmacc_cmd_pkg::intern_cmd_t)) u_sxt_fifo (
    .clk(clk), .s_rst_n(s_rst_n), .push_i(sfifo_push), .data_i(sfifo_in),
    .pop_i(sfifo_pop), .data_o(sfifo_out), .not_empty_o(sfifo_ne), .ovf_o(sfifo_ovf)
  );

  mmacc_fifo #(.DEPTH(RES_FIFO_DEPTH), .payload_t(mmacc_geom_pkg::coef_t)) u_res_fifo (
    .clk(clk), .s_rst_n(s_rst_n), .push_i(res_avail_i), .data_i(res_i),
    .pop_i(rfifo_pop), .data_o(rfifo_data), .not_empty_o(rfifo_ne), .ovf_o(rfifo_ovf)
  );

  // ------------------------------------------------------------
  // GLWE RAM
  // ------------------------------------------------------------
  mmacc_cmd_pkg::gram_wr_t   acc_wr;
  mmacc_geom_pkg::gram_add_t feed_add, acc_add, sxt_add;
  logic                      feed_req, acc_req, sxt_req;
  logic                      feed_gnt, acc_gnt, sxt_gnt;
  logic                      feed_rvld, acc_rvld, sxt_rvld;
  mmacc_geom_pkg::coef_t     rd_data;

  mmacc_gram u_gram (
    .clk(clk), .s_rst_n(s_rst_n), .ld_i(ld_i), .acc_wr_i(acc_wr),
    .feed_req_i(feed_req), .acc_req_i(acc_req), .sxt_req_i(sxt_req),
    .feed_add_i(feed_add), .acc_add_i(acc_add), .sxt_add_i(sxt_add),
    .feed_gnt_o(feed_gnt), .acc_gnt_o(acc_gnt), .sxt_gnt_o(sxt_gnt),
    .feed_rvld_o(feed_rvld), .acc_rvld_o(acc_rvld), .sxt_rvld_o(sxt_rvld),
    .rd_data_o(rd_data)
  );

  // ------------------------------------------------------------
  // Processes
  // ------------------------------------------------------------
  mmacc_feed #(.ENQ_DELAY(ENQ_DELAY)) u_feed (
    .clk(clk), .s_rst_n(s_rst_n),
    .cmd_i(cfifo_data), .cmd_ne_i(cfifo_ne), .cmd_pop_o(cfifo_pop),
    .gnt_i(feed_gnt), .rvld_i(feed_rvld), .rd_data_i(rd_data),
    .req_o(feed_req), .add_o(feed_add),
    .afifo_push_o(afifo_push), .afifo_data_o(afifo_in),
    .feed_o(feed_o), .cmd_enquiry_o(cmd_enquiry_o)
  );

  mmacc_acc u_acc (
    .clk(clk), .s_rst_n(s_rst_n),
    .afifo_i(afifo_out), .afifo_ne_i(afifo_ne), .afifo_pop_o(afifo_pop),
    .res_i(rfifo_data), .res_ne_i(rfifo_ne), .res_pop_o(rfifo_pop),
    .gnt_i(acc_gnt), .rvld_i(acc_rvld), .rd_data_i(rd_data),
    .req_o(acc_req), .add_o(acc_add), .wr_o(acc_wr),
    .sfifo_push_o(sfifo_push), .sfifo_data_o(sfifo_in)
  );

  mmacc_sxt u_sxt (
    .clk(clk), .s_rst_n(s_rst_n),
    .sfifo_i(sfifo_out), .sfifo_ne_i(sfifo_ne), .sfifo_pop_o(sfifo_pop),
    .gnt_i(sxt_gnt), .rvld_i(sxt_rvld), .rd_data_i(rd_data),
    .req_o(sxt_req), .add_o(sxt_add),
    .sxt_o(sxt_o), .done_o(done_o), .done_slot_o(done_slot_o)
  );

  // ------------------------------------------------------------
  // Errors
  // ------------------------------------------------------------
  // Sticky until reset
  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      error_o <= '0;
    end else begin
      error_o.cmd_ovf <= error_o.cmd_ovf | cfifo_ovf;
      error_o.acc_ovf <= error_o.acc_ovf | afifo_ovf;
      error_o.res_ovf <= error_o.res_ovf | rfifo_ovf;
      error_o.sxt_ovf <= error_o.sxt_ovf | sfifo_ovf;
    end
  end

endmodule

`default_nettype wire

// File: mmacc_sxt.sv
// Sample extract process. Output 0 is coefficient 0, output j > 0 is the
// negated coefficient N_COEF - j. done_o comes with the last coefficient.
`timescale 1ns/1ps
`default_nettype none

module mmacc_sxt (
  input  wire logic                       clk,
  input  wire logic                       s_rst_n,
  input  wire mmacc_cmd_pkg::intern_cmd_t sfifo_i,
  input  wire logic                       sfifo_ne_i,
  output logic                            sfifo_pop_o,
  input  wire logic                       gnt_i,
  input  wire logic                       rvld_i,
  input  wire mmacc_geom_pkg::coef_t      rd_data_i,
  output logic                            req_o,
  output mmacc_geom_pkg::gram_add_t       add_o,
  output mmacc_cmd_pkg::sxt_out_t         sxt_o,
  output logic                            done_o,
  output mmacc_geom_pkg::slot_t           done_slot_o
);

  localparam mmacc_geom_pkg::coef_idx_t LAST_IDX =
    mmacc_geom_pkg::coef_idx_t'(mmacc_geom_pkg::N_COEF - 1);

  logic                      busy;
  mmacc_geom_pkg::slot_t     slot_q;
  mmacc_geom_pkg::coef_idx_t j;
  logic                      pend_neg;
  logic                      pend_last;

  assign sfifo_pop_o = ~busy & sfifo_ne_i;
  assign req_o       = busy;
  assign add_o.slot  = slot_q;
  // (N_COEF - j) mod N_COEF
  assign add_o.idx   = -j;

  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      busy <= 1'b0;
      j    <= '0;
    end else if (sfifo_pop_o) begin
      busy <= 1'b1;
      j    <= '0;
    end else if (gnt_i) begin
      busy <= (j != LAST_IDX);
      j    <= j + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (sfifo_pop_o) begin
      slot_q <= sfifo_i.slot;
    end
    if (gnt_i) begin
      pend_neg  <= (j != '0);
      pend_last <= (j == LAST_IDX);
    end
  end

  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      sxt_o       <= '0;
      done_o      <= 1'b0;
      done_slot_o <= '0;
    end else begin
      sxt_o.vld   <= rvld_i;
      sxt_o.data  <= pend_neg ? -rd_data_i : rd_data_i;
      sxt_o.last  <= rvld_i & pend_last;
      sxt_o.slot  <= slot_q;
      done_o      <= rvld_i & pend_last;
      done_slot_o <= slot_q;
    end
  end

endmodule

`default_nettype wire

// File: mmacc_acc.sv
// Accumulate process. Adds the external results of a command into its slot
// with a read-modify-write per coefficient, in index order.
`timescale 1ns/1ps
`default_nettype none

module mmacc_acc (
  input  wire logic                       clk,
  input  wire logic                       s_rst_n,
  input  wire mmacc_cmd_pkg::intern_cmd_t afifo_i,
  input  wire logic                       afifo_ne_i,
  output logic                            afifo_pop_o,
  input  wire mmacc_geom_pkg::coef_t      res_i,
  input  wire logic                       res_ne_i,
  output logic                            res_pop_o,
  input  wire logic                       gnt_i,
  input  wire logic                       rvld_i,
  input  wire mmacc_geom_pkg::coef_t      rd_data_i,
  output logic                            req_o,
  output mmacc_geom_pkg::gram_add_t       add_o,
  output mmacc_cmd_pkg::gram_wr_t         wr_o,
  output logic                            sfifo_push_o,
  output mmacc_cmd_pkg::intern_cmd_t      sfifo_data_o
);

  localparam mmacc_geom_pkg::coef_idx_t LAST_IDX =
    mmacc_geom_pkg::coef_idx_t'(mmacc_geom_pkg::N_COEF - 1);

  logic                      busy;
  logic                      rd_pend;
  mmacc_geom_pkg::slot_t     slot_q;
  mmacc_geom_pkg::coef_idx_t j;
  logic                      wr_last;

  assign afifo_pop_o = ~busy & afifo_ne_i;

  // One read at a time, and only once its result is waiting
  assign req_o      = busy & ~rd_pend & res_ne_i;
  assign add_o.slot = slot_q;
  assign add_o.idx  = j;

  // The result is consumed by the add
  assign res_pop_o = rvld_i;

  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      busy    <= 1'b0;
      rd_pend <= 1'b0;
      j       <= '0;
    end else if (afifo_pop_o) begin
      busy <= 1'b1;
      j    <= '0;
    end else begin
      if (gnt_i) begin
        rd_pend <= 1'b1;
      end
      if (rvld_i) begin
        rd_pend <= 1'b0;
        busy    <= (j != LAST_IDX);
        j       <= j + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (afifo_pop_o) begin
      slot_q <= afifo_i.slot;
    end
  end

  // ------------------------------------------------------------
  // Write-back and hand-off to extract
  // ------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      wr_o         <= '0;
      wr_last      <= 1'b0;
      sfifo_push_o <= 1'b0;
      sfifo_data_o <= '0;
    end else begin
      wr_o.en           <= rvld_i;
      wr_o.add          <= add_o;
      // Sum wraps modulo 2^COEF_W
      wr_o.data         <= rd_data_i + res_i;
      wr_last           <= rvld_i & (j == LAST_IDX);
      sfifo_push_o      <= wr_last;
      sfifo_data_o.slot <= wr_o.add.slot;
    end
  end

endmodule

`default_nettype wire

// File: mmacc_feed.sv
// Feed process. Streams the negacyclic rotation of a slot, one coefficient
// per grant, and generates the command enquiry pulses.
`timescale 1ns/1ps
`default_nettype none

module mmacc_feed #(
  parameter int ENQ_DELAY = 8
) (
  input  wire logic                        clk,
  input  wire logic                        s_rst_n,
  input  wire mmacc_cmd_pkg::pbs_cmd_t     cmd_i,
  input  wire logic                        cmd_ne_i,
  output logic                             cmd_pop_o,
  input  wire logic                        gnt_i,
  input  wire logic                        rvld_i,
  input  wire mmacc_geom_pkg::coef_t       rd_data_i,
  output logic                             req_o,
  output mmacc_geom_pkg::gram_add_t        add_o,
  output logic                             afifo_push_o,
  output mmacc_cmd_pkg::intern_cmd_t       afifo_data_o,
  output mmacc_cmd_pkg::feed_out_t         feed_o,
  output logic                             cmd_enquiry_o
);

  localparam mmacc_geom_pkg::coef_idx_t LAST_IDX =
    mmacc_geom_pkg::coef_idx_t'(mmacc_geom_pkg::N_COEF - 1);

  logic                      busy;
  mmacc_geom_pkg::coef_idx_t j;
  mmacc_cmd_pkg::pbs_cmd_t   cmd_q;
  logic                      pend_neg;
  logic                      pend_sop;
  logic                      pend_eop;
  logic [ENQ_DELAY-1:0]      enq_sr;

  // Command start, the slot goes straight to the accumulate FIFO
  assign cmd_pop_o         = ~busy & cmd_ne_i;
  assign afifo_push_o      = cmd_pop_o;
  assign afifo_data_o.slot = cmd_i.slot;

  // Output j reads index (j - rot) mod N_COEF
  assign req_o      = busy;
  assign add_o.slot = cmd_q.slot;
  assign add_o.idx  = j - cmd_q.rot;

  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      busy <= 1'b0;
      j    <= '0;
    end else if (cmd_pop_o) begin
      busy <= 1'b1;
      j    <= '0;
    end else if (gnt_i) begin
      busy <= (j != LAST_IDX);
      j    <= j + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (cmd_pop_o) begin
      cmd_q <= cmd_i;
    end
  end

  // Flags of the read in flight, used when its data returns
  always_ff @(posedge clk) begin
    if (gnt_i) begin
      pend_neg <= (j < cmd_q.rot);
      pend_sop <= (j == '0);
      pend_eop <= (j == LAST_IDX);
    end
  end

  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      feed_o <= '0;
    end else begin
      feed_o.vld  <= rvld_i;
      feed_o.data <= pend_neg ? -rd_data_i : rd_data_i;
      feed_o.sop  <= rvld_i & pend_sop;
      feed_o.eop  <= rvld_i & pend_eop;
    end
  end

  // ------------------------------------------------------------
  // Enquiry
  // ------------------------------------------------------------
  // First pulse ENQ_DELAY cycles after reset, then one per command taken
  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      enq_sr        <= ENQ_DELAY'(1);
      cmd_enquiry_o <= 1'b0;
    end else begin
      enq_sr        <= enq_sr << 1;
      cmd_enquiry_o <= enq_sr[ENQ_DELAY-1] | cmd_pop_o;
    end
  end

endmodule

`default_nettype wire

// File: mmacc_gram.sv
// GLWE RAM with one write port and one read port shared by fixed priority
// (accumulate, then extract, then feed). Read data and its valid strobe
// come one cycle after the grant.
`timescale 1ns/1ps
`default_nettype none

module mmacc_gram (
  input  wire logic                      clk,
  input  wire logic                      s_rst_n,
  input  wire mmacc_cmd_pkg::gram_wr_t   ld_i,
  input  wire mmacc_cmd_pkg::gram_wr_t   acc_wr_i,
  input  wire logic                      feed_req_i,
  input  wire logic                      acc_req_i,
  input  wire logic                      sxt_req_i,
  input  wire mmacc_geom_pkg::gram_add_t feed_add_i,
  input  wire mmacc_geom_pkg::gram_add_t acc_add_i,
  input  wire mmacc_geom_pkg::gram_add_t sxt_add_i,
  output logic                           feed_gnt_o,
  output logic                           acc_gnt_o,
  output logic                           sxt_gnt_o,
  output logic                           feed_rvld_o,
  output logic                           acc_rvld_o,
  output logic                           sxt_rvld_o,
  output mmacc_geom_pkg::coef_t          rd_data_o
);

  mmacc_geom_pkg::coef_t     mem [mmacc_geom_pkg::GRAM_DEPTH];
  mmacc_cmd_pkg::gram_wr_t   wr;
  mmacc_geom_pkg::gram_add_t rd_add;
  logic                      rd_en;

  // ------------------------------------------------------------
  // Write port
  // ------------------------------------------------------------
  // Loader only writes while no command is in flight
  assign wr = acc_wr_i.en ? acc_wr_i : ld_i;

  always_ff @(posedge clk) begin
    if (wr.en) begin
      mem[wr.add] <= wr.data;
    end
  end

  // ------------------------------------------------------------
  // Read arbiter
  // ------------------------------------------------------------
  assign acc_gnt_o  = acc_req_i;
  assign sxt_gnt_o  = sxt_req_i & ~acc_req_i;
  assign feed_gnt_o = feed_req_i & ~acc_req_i & ~sxt_req_i;
  assign rd_en      = acc_gnt_o | sxt_gnt_o | feed_gnt_o;

  always_comb begin
    if (acc_gnt_o) begin
      rd_add = acc_add_i;
    end else if (sxt_gnt_o) begin
      rd_add = sxt_add_i;
    end else begin
      rd_add = feed_add_i;
    end
  end

  always_ff @(posedge clk) begin
    if (rd_en) begin
      rd_data_o <= mem[rd_add];
    end
  end

  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      feed_rvld_o <= 1'b0;
      acc_rvld_o  <= 1'b0;
      sxt_rvld_o  <= 1'b0;
    end else begin
      feed_rvld_o <= feed_gnt_o;
      acc_rvld_o  <= acc_gnt_o;
      sxt_rvld_o  <= sxt_gnt_o;
    end
  end

endmodule

`default_nettype wire

// File: mmacc_fifo.sv
// Register FIFO without back-pressure. A push into a full FIFO is dropped
// and flagged on ovf_o; pop_i is only legal while not_empty_o is set.
`timescale 1ns/1ps
`default_nettype none

module mmacc_fifo #(
  parameter int  DEPTH     = 2,
  parameter type payload_t = logic
) (
  input  wire logic     clk,
  input  wire logic     s_rst_n,
  input  wire logic     push_i,
  input  wire payload_t data_i,
  input  wire logic     pop_i,
  output payload_t      data_o,
  output logic          not_empty_o,
  output logic          ovf_o
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  payload_t         mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             full;
  logic             wr_en;
  logic             rd_en;

  assign full        = (count == CNT_W'(DEPTH));
  assign not_empty_o = (count != '0);
  // A simultaneous pop frees the entry a full FIFO needs
  assign wr_en       = push_i & (~full | pop_i);
  assign rd_en       = pop_i & not_empty_o;
  assign ovf_o       = push_i & ~wr_en;
  assign data_o      = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_ptr] <= data_i;
    end
  end

  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({wr_en, rd_en})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: mmacc_cmd_pkg.sv
// Commands, streams and error flags exchanged between the processes.
`default_nettype none

package mmacc_cmd_pkg;

  // Sequencer command
  typedef struct packed {
    mmacc_geom_pkg::slot_t     slot;
    mmacc_geom_pkg::coef_idx_t rot;
  } pbs_cmd_t;

  // Slot handed from feed to accumulate, and on to extract
  typedef struct packed {
    mmacc_geom_pkg::slot_t slot;
  } intern_cmd_t;

  typedef struct packed {
    logic                      en;
    mmacc_geom_pkg::gram_add_t add;
    mmacc_geom_pkg::coef_t     data;
  } gram_wr_t;

  typedef struct packed {
    logic                  vld;
    mmacc_geom_pkg::coef_t data;
    logic                  sop;
    logic                  eop;
  } feed_out_t;

  typedef struct packed {
    logic                  vld;
    mmacc_geom_pkg::coef_t data;
    logic                  last;
    mmacc_geom_pkg::slot_t slot;
  } sxt_out_t;

  // Sticky overflow flags, one per FIFO
  typedef struct packed {
    logic cmd_ovf;
    logic acc_ovf;
    logic res_ovf;
    logic sxt_ovf;
  } mmacc_error_t;

endpackage

`default_nettype wire

// File: mmacc_geom_pkg.sv
// Geometry of the GLWE polynomial store.
// N_COEF and SLOT_NB must be powers of two; the modulus is 2^COEF_W,
// so every reduction is plain truncation.
`default_nettype none

package mmacc_geom_pkg;

  // ------------------------------------------------------------
  // Sizes
  // ------------------------------------------------------------
  localparam int COEF_W = 16;
  localparam int N_COEF = 8;
  localparam int SLOT_NB = 4;

  localparam int IDX_W = $clog2(N_COEF);
  localparam int SLOT_W = $clog2(SLOT_NB);
  localparam int GRAM_DEPTH = SLOT_NB * N_COEF;

  // ------------------------------------------------------------
  // Types
  // ------------------------------------------------------------
  typedef logic [COEF_W-1:0] coef_t;
  typedef logic [IDX_W-1:0] coef_idx_t;
  typedef logic [SLOT_W-1:0] slot_t;

  // Slot in the upper bits, so a slot is a contiguous block
  typedef struct packed {
    slot_t     slot;
    coef_idx_t idx;
  } gram_add_t;

endpackage

`default_nettype wire
